// File: mips_lite.f
+incdir+.
src/mips_pkg.sv
src/mips_issue.sv
src/mips_alu.sv
src/mips_regfile.sv
src/mips_core.sv
testbench/mips_checker.sv
testbench/tb_mips_core.sv

// File: mips_lite_defines.svh
// mips lite core parameters
`ifndef MIPS_LITE_DEFINES_SVH
`define MIPS_LITE_DEFINES_SVH

// datapath widths
`define MIPS_DATA_WIDTH 32

// register file
`define MIPS_REG_COUNT 32
`define MIPS_REG_ADDR_WIDTH 5

// instruction queue depth, also the sender's starting credit
`define MIPS_INSTR_CREDITS 2

// result buffer depth on the consumer side
`define MIPS_RES_CREDITS 4

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the mips lite testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module tb_mips_core \
	-f mips_lite.f \
	-o Vtb_mips_core

./obj_dir/Vtb_mips_core | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// File: src/mips_alu.sv
// execute stage
`include "mips_lite_defines.svh"

module mips_alu (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ex_valid,
	input  mips_pkg::alu_op_t   ex_op,
	input  mips_pkg::reg_addr_t ex_dest,
	input  mips_pkg::word_t     ex_a,
	input  mips_pkg::word_t     ex_b,
	output logic                alu_valid,
	output mips_pkg::reg_addr_t alu_dest,
	output mips_pkg::word_t     alu_data,
	output logic                wb_valid,
	output mips_pkg::reg_addr_t wb_dest,
	output mips_pkg::word_t     wb_data
);
	import mips_pkg::*;

	localparam int SH_W = $clog2(`MIPS_DATA_WIDTH);
	localparam int HALF_W = `MIPS_DATA_WIDTH / 2;

	logic [SH_W-1:0] shamt;
	logic            lt;

	// shift amount only uses the low bits of b
	assign shamt = ex_b[SH_W-1:0];
	assign lt = $signed(ex_a) < $signed(ex_b);

	always_comb begin
		case (ex_op)
			ALU_ADD: alu_data = ex_a + ex_b;
			ALU_SUB: alu_data = ex_a - ex_b;
			ALU_AND: alu_data = ex_a & ex_b;
			ALU_OR: alu_data = ex_a | ex_b;
			ALU_XOR: alu_data = ex_a ^ ex_b;
			ALU_NOR: alu_data = ~(ex_a | ex_b);
			ALU_SLT: alu_data = {{(`MIPS_DATA_WIDTH - 1){1'b0}}, lt};
			ALU_SLL: alu_data = ex_a << shamt;
			ALU_SRL: alu_data = ex_a >> shamt;
			ALU_SRA: alu_data = $signed(ex_a) >>> shamt;
			ALU_LUI: alu_data = {ex_b[HALF_W-1:0], {HALF_W{1'b0}}};
			default: alu_data = '0;
		endcase
	end

	// forward path back to issue
	assign alu_valid = ex_valid;
	assign alu_dest = ex_dest;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_valid <= 1'b0;
		else
			wb_valid <= ex_valid;
	end

	always_ff @(posedge clk) begin
		wb_dest <= ex_dest;
		wb_data <= alu_data;
	end

endmodule

// File: src/mips_core.sv
// mips lite core top

module mips_core (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_valid,
	input  mips_pkg::word_t     instr,
	output logic                instr_credit,
	input  logic                res_credit,
	output logic                res_valid,
	output mips_pkg::reg_addr_t res_reg,
	output mips_pkg::word_t     res_data
);
	import mips_pkg::*;

	reg_addr_t rd_addr_a;
	reg_addr_t rd_addr_b;
	word_t     rd_data_a;
	word_t     rd_data_b;
	logic      ex_valid;
	alu_op_t   ex_op;
	reg_addr_t ex_dest;
	word_t     ex_a;
	word_t     ex_b;
	logic      alu_valid;
	reg_addr_t alu_dest;
	word_t     alu_data;
	logic      wb_valid;
	reg_addr_t wb_dest;
	word_t     wb_data;

	mips_issue u_issue (
		.clk(clk), .rst_n(rst_n),
		.instr_valid(instr_valid), .instr(instr), .instr_credit(instr_credit),
		.res_credit(res_credit),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.alu_valid(alu_valid), .alu_dest(alu_dest), .alu_data(alu_data),
		.wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data),
		.ex_valid(ex_valid), .ex_op(ex_op), .ex_dest(ex_dest), .ex_a(ex_a), .ex_b(ex_b)
	);

	mips_alu u_alu (
		.clk(clk), .rst_n(rst_n),
		.ex_valid(ex_valid), .ex_op(ex_op), .ex_dest(ex_dest), .ex_a(ex_a), .ex_b(ex_b),
		.alu_valid(alu_valid), .alu_dest(alu_dest), .alu_data(alu_data),
		.wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data)
	);

	mips_regfile u_regfile (
		.clk(clk), .rst_n(rst_n),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data),
		.res_valid(res_valid), .res_reg(res_reg), .res_data(res_data)
	);

endmodule

// File: src/mips_issue.sv
// instruction issue stage
`include "mips_lite_defines.svh"

module mips_issue (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_valid,
	input  mips_pkg::word_t     instr,
	output logic                instr_credit,
	input  logic                res_credit,
	output mips_pkg::reg_addr_t rd_addr_a,
	output mips_pkg::reg_addr_t rd_addr_b,
	input  mips_pkg::word_t     rd_data_a,
	input  mips_pkg::word_t     rd_data_b,
	input  logic                alu_valid,
	input  mips_pkg::reg_addr_t alu_dest,
	input  mips_pkg::word_t     alu_data,
	input  logic                wb_valid,
	input  mips_pkg::reg_addr_t wb_dest,
	input  mips_pkg::word_t     wb_data,
	output logic                ex_valid,
	output mips_pkg::alu_op_t   ex_op,
	output mips_pkg::reg_addr_t ex_dest,
	output mips_pkg::word_t     ex_a,
	output mips_pkg::word_t     ex_b
);
	import mips_pkg::*;

	localparam int DEPTH = `MIPS_INSTR_CREDITS;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CRED_W = $clog2(`MIPS_RES_CREDITS + 1);
	localparam int IMM_W = 16;

	typedef enum logic [1:0] {B_REG, B_SIMM, B_ZIMM, B_SHAMT} b_src_t;

	word_t              q_mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   q_count;
	logic [CRED_W-1:0]  out_credits;
	word_t              head;
	opcode_t            opcode;
	funct_t             funct;
	logic               supported;
	logic               is_rtype;
	logic               is_shift;
	logic               fire;
	logic               issue_valid;
	alu_op_t            dec_op;
	reg_addr_t          dec_dest;
	b_src_t             b_src;
	word_t              fwd_a;
	word_t              fwd_b;
	word_t              op_b;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// younger producer wins, r0 never forwards
	function automatic word_t forward(input reg_addr_t addr, input word_t rf_data);
		word_t data;
		data = rf_data;
		if (wb_valid && wb_dest != '0 && wb_dest == addr)
			data = wb_data;
		if (alu_valid && alu_dest != '0 && alu_dest == addr)
			data = alu_data;
		return data;
	endfunction

	// instruction queue
	always_ff @(posedge clk) begin
		if (instr_valid)
			q_mem[wr_ptr] <= instr;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_count <= '0;
		end else begin
			if (instr_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (fire)
				rd_ptr <= next_ptr(rd_ptr);
			case ({instr_valid, fire})
				2'b10: q_count <= q_count + 1'b1;
				2'b01: q_count <= q_count - 1'b1;
				default: q_count <= q_count;
			endcase
		end
	end

	assign head = q_mem[rd_ptr];
	assign opcode = opcode_t'(head[31:26]);
	assign funct = funct_t'(head[5:0]);

	// decode of the queue head
	always_comb begin
		supported = 1'b1;
		dec_op = ALU_ADD;
		case (opcode)
			OP_RTYPE: begin
				case (funct)
					FN_ADD: dec_op = ALU_ADD;
					FN_SUB: dec_op = ALU_SUB;
					FN_AND: dec_op = ALU_AND;
					FN_OR: dec_op = ALU_OR;
					FN_XOR: dec_op = ALU_XOR;
					FN_NOR: dec_op = ALU_NOR;
					FN_SLT: dec_op = ALU_SLT;
					FN_SLL, FN_SLLV: dec_op = ALU_SLL;
					FN_SRL, FN_SRLV: dec_op = ALU_SRL;
					FN_SRA, FN_SRAV: dec_op = ALU_SRA;
					default: supported = 1'b0;
				endcase
			end
			OP_ADDI: dec_op = ALU_ADD;
			OP_SLTI: dec_op = ALU_SLT;
			OP_ANDI: dec_op = ALU_AND;
			OP_ORI: dec_op = ALU_OR;
			OP_XORI: dec_op = ALU_XOR;
			OP_LUI: dec_op = ALU_LUI;
			default: supported = 1'b0;
		endcase
	end

	assign is_rtype = (opcode == OP_RTYPE);
	assign is_shift = is_rtype && (dec_op == ALU_SLL || dec_op == ALU_SRL || dec_op == ALU_SRA);
	assign dec_dest = is_rtype ? head[15:11] : head[20:16];

	// shifts take rt as the value and rs as the amount
	assign rd_addr_a = is_shift ? head[20:16] : head[25:21];
	assign rd_addr_b = is_shift ? head[25:21] : head[20:16];

	always_comb begin
		case (opcode)
			// funct bit 2 marks the variable shifts
			OP_RTYPE: b_src = (is_shift && !head[2]) ? B_SHAMT : B_REG;
			OP_ADDI, OP_SLTI: b_src = B_SIMM;
			default: b_src = B_ZIMM;
		endcase
	end

	always_comb begin
		fwd_a = forward(rd_addr_a, rd_data_a);
		fwd_b = forward(rd_addr_b, rd_data_b);
	end

	always_comb begin
		case (b_src)
			B_SIMM: op_b = {{(`MIPS_DATA_WIDTH - IMM_W){head[IMM_W-1]}}, head[IMM_W-1:0]};
			B_ZIMM: op_b = {{(`MIPS_DATA_WIDTH - IMM_W){1'b0}}, head[IMM_W-1:0]};
			B_SHAMT: op_b = {{(`MIPS_DATA_WIDTH - 5){1'b0}}, head[10:6]};
			default: op_b = fwd_b;
		endcase
	end

	// unsupported words leave without an output credit
	assign fire = (q_count != '0) && (!supported || out_credits != '0);
	assign issue_valid = fire && supported;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_credits <= CRED_W'(`MIPS_RES_CREDITS);
			instr_credit <= 1'b0;
			ex_valid <= 1'b0;
		end else begin
			case ({issue_valid, res_credit})
				2'b10: out_credits <= out_credits - 1'b1;
				2'b01: out_credits <= out_credits + 1'b1;
				default: out_credits <= out_credits;
			endcase
			instr_credit <= fire;
			ex_valid <= issue_valid;
		end
	end

	always_ff @(posedge clk) begin
		ex_op <= dec_op;
		ex_dest <= dec_dest;
		ex_a <= fwd_a;
		ex_b <= op_b;
	end

	// sender must hold a credit for every beat
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		instr_valid |-> (q_count != CNT_W'(DEPTH)))
		else $error("instruction pushed into full queue");

	// consumer returned more credits than results taken
	a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
		out_credits <= CRED_W'(`MIPS_RES_CREDITS))
		else $error("output credit count above result buffer depth");

endmodule

// File: src/mips_pkg.sv
// mips lite types
`include "mips_lite_defines.svh"

package mips_pkg;

	typedef logic [`MIPS_DATA_WIDTH-1:0] word_t;
	typedef logic [`MIPS_REG_ADDR_WIDTH-1:0] reg_addr_t;

	// major opcodes handled by the core
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_ADDI  = 6'h08,
		OP_SLTI  = 6'h0a,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_XORI  = 6'h0e,
		OP_LUI   = 6'h0f
	} opcode_t;

	// r-type function field
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_SLLV = 6'h04,
		FN_SRLV = 6'h06,
		FN_SRAV = 6'h07,
		FN_ADD  = 6'h20,
		FN_SUB  = 6'h22,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_t;

endpackage

// File: src/mips_regfile.sv
// register file and result port
`include "mips_lite_defines.svh"

module mips_regfile (
	input  logic                clk,
	input  logic                rst_n,
	input  mips_pkg::reg_addr_t rd_addr_a,
	input  mips_pkg::reg_addr_t rd_addr_b,
	output mips_pkg::word_t     rd_data_a,
	output mips_pkg::word_t     rd_data_b,
	input  logic                wb_valid,
	input  mips_pkg::reg_addr_t wb_dest,
	input  mips_pkg::word_t     wb_data,
	output logic                res_valid,
	output mips_pkg::reg_addr_t res_reg,
	output mips_pkg::word_t     res_data
);
	import mips_pkg::*;

	word_t regs [`MIPS_REG_COUNT];

	// r0 is hardwired, writes to it are dropped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `MIPS_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wb_valid && wb_dest != '0) begin
			regs[wb_dest] <= wb_data;
		end
	end

	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

	// writeback stage doubles as the result stream
	assign res_valid = wb_valid;
	assign res_reg = wb_dest;
	assign res_data = wb_data;

	a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_addr_a != '0 || rd_data_a == '0) && (rd_addr_b != '0 || rd_data_b == '0))
		else $error("register 0 read back nonzero");

endmodule

// File: testbench/mips_checker.sv
// result stream checker

module mips_checker #(
	parameter int RES_CREDITS = 4
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                exp_push,
	input  mips_pkg::reg_addr_t exp_reg,
	input  mips_pkg::word_t     exp_data,
	input  logic                res_valid,
	input  mips_pkg::reg_addr_t res_reg,
	input  mips_pkg::word_t     res_data,
	input  logic                res_credit,
	input  logic                run_done,
	output int                  data_errors,
	output int                  stream_errors,
	output int                  results_seen
);
	import mips_pkg::*;

	reg_addr_t exp_reg_q [$];
	word_t     exp_data_q [$];
	reg_addr_t want_reg;
	word_t     want_data;
	int        outstanding;
	logic      done_seen;

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_errors = 0;
			stream_errors = 0;
			results_seen = 0;
			outstanding = 0;
			done_seen = 1'b0;
			exp_reg_q.delete();
			exp_data_q.delete();
		end else begin
			if (exp_push) begin
				exp_reg_q.push_back(exp_reg);
				exp_data_q.push_back(exp_data);
			end

			if (res_valid) begin
				// results not yet credited back by the consumer
				if (outstanding >= RES_CREDITS) begin
					$display("result for r%0d sent while the consumer buffer was full",
						res_reg);
					stream_errors++;
				end
				outstanding++;
				if (exp_reg_q.size() == 0) begin
					$display("unexpected extra result r%0d = %08h", res_reg, res_data);
					stream_errors++;
				end else begin
					want_reg = exp_reg_q.pop_front();
					want_data = exp_data_q.pop_front();
					if (res_reg !== want_reg) begin
						$display("FAILED res_reg exp %02h got %02h", want_reg, res_reg);
						data_errors++;
					end
					if (res_data !== want_data) begin
						$display("FAILED res_data exp %08h got %08h", want_data, res_data);
						data_errors++;
					end
					results_seen++;
				end
			end

			if (res_credit && outstanding > 0)
				outstanding--;

			// anything still queued at the end never came out
			if (run_done && !done_seen) begin
				done_seen = 1'b1;
				if (exp_reg_q.size() != 0) begin
					$display("%0d expected results never arrived", exp_reg_q.size());
					stream_errors += exp_reg_q.size();
				end
			end
		end
	end

endmodule

// File: testbench/mips_golden.hex
// instruction word, result flag (1 = result expected), destination, value
// lines with flag 0 hold words the core must drop
3c018000 1 01 80000000
34211234 1 01 80001234
2002fffb 1 02 fffffffb
20030064 1 03 00000064
00432020 1 04 0000005f
00622822 1 05 00000069
00223024 1 06 80001230
00643825 1 07 0000007f
00234026 1 08 80001250
00404827 1 09 00000004
0043502a 1 0a 00000001
0061582a 1 0b 00000000
00036100 1 0c 00000640
00016a02 1 0d 00800012
00017203 1 0e ff800012
200f0004 1 0f 00000004
01e28004 1 10 ffffffb0
01e18806 1 11 08000123
01e19007 1 12 f8000123
8c410000 0 00 00000000
2853fffc 1 13 00000001
3054fff0 1 14 0000fff0
38558001 1 15 ffff7ffa
34168000 1 16 00008000
08000010 0 00 00000000
20000055 1 00 00000055
0000b820 1 17 00000000
0002c7c3 1 18 ffffffff
0302c822 1 19 00000004
0338d020 1 1a 00000003
0359d826 1 1b 00000007
0361e027 1 1c 7fffedc8
00220018 0 00 00000000

// File: testbench/tb_mips_core.sv
// mips core testbench
`include "mips_lite_defines.svh"

module tb_mips_core;
	import mips_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 10;
	localparam int CYCLES_PER_LINE = 40;
	localparam int MAX_LINES = 64;
	localparam int SETTLE_CYCLES = 20;
	localparam int DRAIN_CYCLES = 200;

	logic      clk;
	logic      rst_n;
	logic      instr_valid;
	word_t     instr;
	logic      instr_credit;
	logic      res_credit;
	logic      res_valid;
	reg_addr_t res_reg;
	word_t     res_data;

	logic      exp_push;
	reg_addr_t exp_reg;
	word_t     exp_data;
	logic      run_done;
	int        data_errors;
	int        stream_errors;
	int        results_seen;
	int        bench_errors;

	// four columns per line: word, result flag, destination, value
	logic [31:0] golden [4*MAX_LINES];
	int          n_lines;
	int          n_expected;
	logic        loaded;

	logic [31:0] lcg_state;
	int          line_idx;
	int          send_credits;
	int          owed_credits;
	int          hold_cycles;
	logic        held_once;
	int          settle;
	int          drain;

	mips_core UUT (
		.clk(clk), .rst_n(rst_n),
		.instr_valid(instr_valid), .instr(instr), .instr_credit(instr_credit),
		.res_credit(res_credit),
		.res_valid(res_valid), .res_reg(res_reg), .res_data(res_data)
	);

	mips_checker #(.RES_CREDITS(`MIPS_RES_CREDITS)) u_checker (
		.clk(clk), .rst_n(rst_n),
		.exp_push(exp_push), .exp_reg(exp_reg), .exp_data(exp_data),
		.res_valid(res_valid), .res_reg(res_reg), .res_data(res_data),
		.res_credit(res_credit), .run_done(run_done),
		.data_errors(data_errors), .stream_errors(stream_errors),
		.results_seen(results_seen)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic load_golden();
		// flag slots left unwritten never read as 0 or 1
		for (int i = 0; i < 4 * MAX_LINES; i++)
			golden[i] = 32'hffff_0000 | 32'(i);
		$readmemh("testbench/mips_golden.hex", golden);
		n_lines = 0;
		n_expected = 0;
		while (n_lines < MAX_LINES && golden[4 * n_lines + 1] <= 32'd1) begin
			if (golden[4 * n_lines + 1] == 32'd1)
				n_expected++;
			n_lines++;
		end
	endtask

	// one falling edge worth of stimulus and credit return
	task automatic drive_cycle();
		int base;
		if (instr_credit)
			send_credits++;
		if (send_credits > `MIPS_INSTR_CREDITS) begin
			$display("core returned more input credits than its queue holds");
			bench_errors++;
			send_credits = `MIPS_INSTR_CREDITS;
		end
		if (res_valid)
			owed_credits++;
		instr_valid = 1'b0;
		exp_push = 1'b0;
		res_credit = 1'b0;

		lcg_state = lcg_next(lcg_state);
		if (line_idx < n_lines && send_credits > 0 && lcg_state[31:30] != 2'b00) begin
			base = 4 * line_idx;
			instr_valid = 1'b1;
			instr = golden[base];
			if (golden[base + 1] == 32'd1) begin
				exp_push = 1'b1;
				exp_reg = golden[base + 2][4:0];
				exp_data = golden[base + 3];
			end
			send_credits--;
			line_idx++;
		end

		lcg_state = lcg_next(lcg_state);
		if (hold_cycles > 0) begin
			hold_cycles--;
		end else if (line_idx < n_lines &&
			((line_idx >= n_lines / 2 && !held_once) || lcg_state[31:27] == 5'd0)) begin
			// long stall so the core runs out of output credit
			hold_cycles = 16 + int'(lcg_state[3:0]);
			held_once = 1'b1;
		end else if (owed_credits > 0 && lcg_state[26]) begin
			res_credit = 1'b1;
			owed_credits--;
		end
	endtask

	initial begin
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		res_credit = 1'b0;
		exp_push = 1'b0;
		exp_reg = '0;
		exp_data = '0;
		run_done = 1'b0;
		bench_errors = 0;
		lcg_state = 32'hea68;
		line_idx = 0;
		send_credits = `MIPS_INSTR_CREDITS;
		owed_credits = 0;
		hold_cycles = 0;
		held_once = 1'b0;
		settle = 0;
		drain = 0;
		loaded = 1'b0;
		load_golden();
		loaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// keep going a while after the last result to catch extras
		while (settle < SETTLE_CYCLES) begin
			@(negedge clk);
			drive_cycle();
			if (line_idx == n_lines) begin
				// give outstanding results a bounded time to drain
				if (results_seen == n_expected || drain >= DRAIN_CYCLES)
					settle++;
				else
					drain++;
			end
		end
		run_done = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);

		$display("errors: data %0d, stream %0d, bench %0d (%0d of %0d results checked)",
			data_errors, stream_errors, bench_errors, results_seen, n_expected);
		if (data_errors == 0 && stream_errors == 0 && bench_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (loaded);
		#((n_lines * CYCLES_PER_LINE + RESET_CYCLES) * CLK_PERIOD);
		$display("timeout: run did not finish, %0d of %0d results checked",
			results_seen, n_expected);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
